// File: spi_params.svh
// Build-time sizes shared by the SPI master and its testbench
// Only an 8-bit transfer is supported, other byte widths are rejected by assertions
// SPI_SLV_W must be wide enough to index SPI_NUM_SLAVES chip selects
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Chip-select lines and the index that picks one
`define SPI_NUM_SLAVES 4
`define SPI_SLV_W      2

// Half-period divisor and the ct2 / t2c delay fields
`define SPI_DIV_W      8
`define SPI_DLY_W      8

// Transfer width and the bit counter that spans it
`define SPI_BYTE_W     8
`define SPI_BCNT_W     4

`endif

// File: spi_pkg.sv
// Types for the SPI master ports and controller
// Field widths come from spi_params.svh
`include "spi_params.svh"

package spi_pkg;

  // --------------------------------------------------
  // Per-transfer command
  // --------------------------------------------------
  typedef struct packed {
    logic [`SPI_SLV_W-1:0]  slave;    // Chip select index
    logic                   quad;     // 1 = four lanes, 0 = lane 0 only
    logic [`SPI_BYTE_W-1:0] tx_byte;  // Sent LSB first
  } spi_cmd_t;

  // --------------------------------------------------
  // Per-transfer timing, all in pclk cycles
  // --------------------------------------------------
  typedef struct packed {
    logic [`SPI_DIV_W-1:0] half_div;  // sclk half period, 0 acts as 1
    logic [`SPI_DLY_W-1:0] ct2_dly;   // cs low to first clock
    logic [`SPI_DLY_W-1:0] t2c_dly;   // last clock to cs high
  } spi_cfg_t;

  // One bit per data lane, used for mosi, miso and output enables
  typedef struct packed {
    logic lane3;
    logic lane2;
    logic lane1;
    logic lane0;
  } spi_lanes_t;

  // Controller sequence
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LEAD,
    ST_SHIFT,
    ST_TAIL,
    ST_FINISH
  } spi_state_t;

endpackage

// File: spi_sclk_gen.sv
// sclk divider for CPOL 0 only with sclk idling low
// rise and fall are high in the pclk cycle that ends with the sclk edge
// half_div must be nonzero as the controller maps 0 to 1
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_sclk_gen (
  input  logic                  pclk,
  input  logic                  reset,
  input  logic                  clk_en,
  input  logic [`SPI_DIV_W-1:0] half_div,
  output logic                  sclk,
  output logic                  rise,
  output logic                  fall
);

  // Counts pclk cycles inside one sclk half period
  logic [`SPI_DIV_W-1:0] half_cnt;
  logic                  half_end;

  // --------------------------------------------------
  // Edge events
  // --------------------------------------------------
  // Last pclk of the current half period
  assign half_end = clk_en && (half_cnt == half_div - 1'b1);

  // Direction taken from the level being left
  assign rise = half_end && !sclk;
  assign fall = half_end && sclk;

  // --------------------------------------------------
  // Divider and sclk register
  // --------------------------------------------------
  always_ff @(posedge pclk) begin
    if (reset) begin
      half_cnt <= '0;
      sclk     <= 1'b0;
    end else if (!clk_en) begin
      // Park low and restart the count for the next transfer
      half_cnt <= '0;
      sclk     <= 1'b0;
    end else if (half_end) begin
      half_cnt <= '0;
      sclk     <= ~sclk;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Divisor of 0 would wrap the half period count
  a_div_nonzero: assert property (
    @(posedge pclk) disable iff (reset)
    clk_en |-> (half_div != '0)
  );

  // Controller drops clk_en only on the final falling edge
  a_sclk_parked: assert property (
    @(posedge pclk) disable iff (reset)
    !clk_en |-> !sclk
  );

endmodule

// File: spi_shift_engine.sv
// Transmit and receive shifters for single and quad lane transfers
// LSB first, CPOL 0 / CPHA 0, fixed 8-bit transfer
// mosi moves on the falling sclk edge and miso is taken on the rising edge
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_shift_engine (
  input  logic                   pclk,
  input  logic                   reset,
  input  logic                   load,
  input  logic                   quad,
  input  logic [`SPI_BYTE_W-1:0] tx_byte,
  input  logic                   shifting,
  input  logic                   rise,
  input  logic                   fall,
  input  spi_pkg::spi_lanes_t    miso,
  output spi_pkg::spi_lanes_t    mosi,
  output spi_pkg::spi_lanes_t    mosi_oe,
  output logic [`SPI_BYTE_W-1:0] rx_byte,
  output logic                   last_fall
);

  logic [`SPI_BYTE_W-1:0] tx_sh;
  logic [`SPI_BYTE_W-1:0] rx_sh;
  logic [`SPI_BCNT_W-1:0] bit_cnt;
  logic [`SPI_BCNT_W-1:0] step;
  logic                   quad_q;
  logic [3:0]             miso_nib;

  // Bits moved per sclk cycle
  assign step = quad_q ? `SPI_BCNT_W'(4) : `SPI_BCNT_W'(1);

  // Lane 3 is the high bit of the nibble
  assign miso_nib = {miso.lane3, miso.lane2, miso.lane1, miso.lane0};

  // --------------------------------------------------
  // Lane drive
  // --------------------------------------------------
  // Low bits of the shifter sit on the lanes
  always_comb begin
    mosi       = '0;
    mosi.lane0 = tx_sh[0];
    if (quad_q) begin
      mosi.lane1 = tx_sh[1];
      mosi.lane2 = tx_sh[2];
      mosi.lane3 = tx_sh[3];
    end
  end

  // Lane 0 always, upper lanes only in quad mode
  always_comb begin
    mosi_oe = '0;
    if (shifting) begin
      mosi_oe.lane0 = 1'b1;
      mosi_oe.lane1 = quad_q;
      mosi_oe.lane2 = quad_q;
      mosi_oe.lane3 = quad_q;
    end
  end

  // --------------------------------------------------
  // Mode and bit count
  // --------------------------------------------------
  always_ff @(posedge pclk) begin
    if (reset) begin
      bit_cnt <= '0;
      quad_q  <= 1'b0;
    end else if (load) begin
      bit_cnt <= '0;
      quad_q  <= quad;
    end else if (shifting && rise) begin
      // Counted after each sample
      bit_cnt <= bit_cnt + step;
    end
  end

  // --------------------------------------------------
  // Shift registers
  // --------------------------------------------------
  always_ff @(posedge pclk) begin
    // Next bit or nibble on each falling edge
    if (load) begin
      tx_sh <= tx_byte;
    end else if (shifting && fall) begin
      tx_sh <= quad_q ? (tx_sh >> 4) : (tx_sh >> 1);
    end
    // Fill from the top so the first bit lands in bit 0
    if (shifting && rise) begin
      rx_sh <= quad_q ? {miso_nib, rx_sh[`SPI_BYTE_W-1:4]}
                      : {miso.lane0, rx_sh[`SPI_BYTE_W-1:1]};
    end
  end

  assign rx_byte = rx_sh;

  // Falling edge after the last sample closes the byte
  assign last_fall = shifting && fall && (bit_cnt == `SPI_BCNT_W'(`SPI_BYTE_W));

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Clock gen runs only inside the controller's active window
  a_rise_in_window: assert property (
    @(posedge pclk) disable iff (reset)
    rise |-> shifting
  );

  // Controller stops the clock on last_fall, so no overrun
  a_bit_cnt_range: assert property (
    @(posedge pclk) disable iff (reset)
    (`SPI_BYTE_W == 8) && (bit_cnt <= `SPI_BCNT_W'(`SPI_BYTE_W))
  );

endmodule

// File: spi_master_ctrl.sv
// Transfer sequencer for the SPI master
// A start while busy is dropped and cmd and cfg are taken only when idle
// cs rises t2c_dly + 1 cycles after the final sclk fall and done follows one cycle later
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_master_ctrl (
  input  logic                       pclk,
  input  logic                       reset,
  input  logic                       start,
  input  spi_pkg::spi_cmd_t          cmd,
  input  spi_pkg::spi_cfg_t          cfg,
  input  logic                       last_fall,
  output logic [`SPI_NUM_SLAVES-1:0] cs,
  output logic                       clk_en,
  output logic [`SPI_DIV_W-1:0]      half_div,
  output logic                       load,
  output logic                       quad,
  output logic [`SPI_BYTE_W-1:0]     tx_byte,
  output logic                       shifting,
  output logic                       busy,
  output logic                       done
);

  spi_pkg::spi_state_t   state;
  spi_pkg::spi_cfg_t     cfg_q;
  logic [`SPI_DLY_W-1:0] dly_cnt;
  logic                  accept;

  assign accept = start && (state == spi_pkg::ST_IDLE);

  // Engine latches the byte and mode on the accept cycle
  assign load    = accept;
  assign quad    = cmd.quad;
  assign tx_byte = cmd.tx_byte;

  // --------------------------------------------------
  // Status and clock control
  // --------------------------------------------------
  assign busy     = (state != spi_pkg::ST_IDLE);
  assign clk_en   = (state == spi_pkg::ST_SHIFT);
  // Lanes stay driven from cs low through the tail
  assign shifting = (state == spi_pkg::ST_LEAD) || (state == spi_pkg::ST_SHIFT) ||
                    (state == spi_pkg::ST_TAIL);
  assign half_div = cfg_q.half_div;

  // Timing captured at accept with divisor 0 run as 1
  always_ff @(posedge pclk) begin
    if (accept) begin
      cfg_q.half_div <= (cfg.half_div == '0) ? `SPI_DIV_W'(1) : cfg.half_div;
      cfg_q.ct2_dly  <= cfg.ct2_dly;
      cfg_q.t2c_dly  <= cfg.t2c_dly;
    end
  end

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge pclk) begin
    if (reset) begin
      state   <= spi_pkg::ST_IDLE;
      cs      <= '1;
      dly_cnt <= '0;
      done    <= 1'b0;
    end else begin
      // Pulse in the cycle busy drops
      done <= (state == spi_pkg::ST_FINISH);
      case (state)
        spi_pkg::ST_IDLE: begin
          if (accept) begin
            // One-cold select
            cs      <= ~(`SPI_NUM_SLAVES'(1) << cmd.slave);
            dly_cnt <= '0;
            // Zero lead delay starts the clock with cs
            state   <= (cfg.ct2_dly == '0) ? spi_pkg::ST_SHIFT : spi_pkg::ST_LEAD;
          end
        end
        spi_pkg::ST_LEAD: begin
          // ct2_dly cycles of cs low before clk_en
          if (dly_cnt == cfg_q.ct2_dly - 1'b1) begin
            state <= spi_pkg::ST_SHIFT;
          end else begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        spi_pkg::ST_SHIFT: begin
          if (last_fall) begin
            dly_cnt <= '0;
            state   <= spi_pkg::ST_TAIL;
          end
        end
        spi_pkg::ST_TAIL: begin
          // t2c_dly + 1 cycles counted from the first low sclk cycle
          if (dly_cnt == cfg_q.t2c_dly) begin
            cs    <= '1;
            state <= spi_pkg::ST_FINISH;
          end else begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        spi_pkg::ST_FINISH: state <= spi_pkg::ST_IDLE;
        default:            state <= spi_pkg::ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Exactly one select low while the lanes are live
  a_cs_onecold: assert property (
    @(posedge pclk) disable iff (reset)
    shifting |-> $onehot(~cs)
  );

  a_cs_idle_high: assert property (
    @(posedge pclk) disable iff (reset)
    !busy |-> (&cs)
  );

  a_done_pulse: assert property (
    @(posedge pclk) disable iff (reset)
    done |=> !done
  );

endmodule

// File: spi_master_top.sv
// SPI master top, CPOL 0 / CPHA 0, one 8-bit transfer per start pulse
// Single lane uses mosi0/miso0, quad mode uses all four lanes
// rx_data holds from done until the next accepted start
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_master_top (
  input  logic                       pclk,
  input  logic                       reset,
  input  logic                       start,
  input  spi_pkg::spi_cmd_t          cmd,
  input  spi_pkg::spi_cfg_t          cfg,
  input  spi_pkg::spi_lanes_t        miso,
  output logic                       busy,
  output logic                       done,
  output logic [`SPI_BYTE_W-1:0]     rx_data,
  output logic [`SPI_NUM_SLAVES-1:0] cs,
  output logic                       sclk,
  output spi_pkg::spi_lanes_t        mosi,
  output spi_pkg::spi_lanes_t        mosi_oe
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------
  // Controller to clock gen
  logic                   clk_en;
  logic [`SPI_DIV_W-1:0]  half_div;
  // Controller to shift engine
  logic                   load;
  logic                   quad;
  logic [`SPI_BYTE_W-1:0] tx_byte;
  logic                   shifting;
  logic                   last_fall;
  // Clock gen edge events
  logic                   rise;
  logic                   fall;

  spi_master_ctrl u_ctrl (
    .pclk      (pclk),
    .reset     (reset),
    .start     (start),
    .cmd       (cmd),
    .cfg       (cfg),
    .last_fall (last_fall),
    .cs        (cs),
    .clk_en    (clk_en),
    .half_div  (half_div),
    .load      (load),
    .quad      (quad),
    .tx_byte   (tx_byte),
    .shifting  (shifting),
    .busy      (busy),
    .done      (done)
  );

  spi_sclk_gen u_sclk_gen (
    .pclk     (pclk),
    .reset    (reset),
    .clk_en   (clk_en),
    .half_div (half_div),
    .sclk     (sclk),
    .rise     (rise),
    .fall     (fall)
  );

  spi_shift_engine u_shift (
    .pclk      (pclk),
    .reset     (reset),
    .load      (load),
    .quad      (quad),
    .tx_byte   (tx_byte),
    .shifting  (shifting),
    .rise      (rise),
    .fall      (fall),
    .miso      (miso),
    .mosi      (mosi),
    .mosi_oe   (mosi_oe),
    .rx_byte   (rx_data),
    .last_fall (last_fall)
  );

endmodule

// File: tb_spi_clk.sv
// Clock and reset source for the SPI master testbench
// pclk period 100 ns, reset held high over the first 16 rising edges
`timescale 1ns/100ps

module tb_spi_clk (
  output logic pclk,
  output logic reset
);

  initial begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;
  end

  // Released 1 ns after the 16th edge, same offset as the other inputs
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge pclk);
    #1 reset = 1'b0;
  end

endmodule

// File: tb_spi_master.sv
// Random single and quad lane transfers against a slave model
// Timing rules are checked in pclk cycles from the DUT pins
// Assumes the 4 slaves and 8-bit byte of spi_params.svh
`timescale 1ns/100ps
`include "spi_params.svh"

module tb_spi_master;

  localparam int N_EACH   = 40;
  localparam int WAIT_MAX = 2000;

  logic                       pclk;
  logic                       reset;
  logic                       start;
  spi_pkg::spi_cmd_t          cmd;
  spi_pkg::spi_cfg_t          cfg;
  spi_pkg::spi_lanes_t        miso;
  logic                       busy;
  logic                       done;
  logic [`SPI_BYTE_W-1:0]     rx_data;
  logic [`SPI_NUM_SLAVES-1:0] cs;
  logic                       sclk;
  spi_pkg::spi_lanes_t        mosi;
  spi_pkg::spi_lanes_t        mosi_oe;

  integer seed;
  int     n_pass;
  int     n_fail;
  int     test_err;
  int     cur_test;
  logic   timeout_hit;

  // Expected values of the transfer in flight
  int                         exp_slave;
  logic                       exp_quad;
  logic [`SPI_BYTE_W-1:0]     exp_reply;
  logic [`SPI_NUM_SLAVES-1:0] exp_cs;
  spi_pkg::spi_lanes_t        exp_oe;

  // Slave model state
  logic [`SPI_BYTE_W-1:0] slv_cap;
  int                     slv_bit;

  // Monitor records in pclk cycles
  int cyc;
  int accept_cyc;
  int cs_fall_cyc;
  int first_rise_cyc;
  int last_fall_cyc;
  int cs_rise_cyc;
  int done_cyc;
  int rise_cnt;
  int done_cnt;

  tb_spi_clk u_clk (
    .pclk  (pclk),
    .reset (reset)
  );

  spi_master_top dut (
    .pclk    (pclk),
    .reset   (reset),
    .start   (start),
    .cmd     (cmd),
    .cfg     (cfg),
    .miso    (miso),
    .busy    (busy),
    .done    (done),
    .rx_data (rx_data),
    .cs      (cs),
    .sclk    (sclk),
    .mosi    (mosi),
    .mosi_oe (mosi_oe)
  );

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Bit i alone on lane 0, or bits i+3..i on lanes 3..0 in quad mode
  function automatic spi_pkg::spi_lanes_t lanes_for(input logic [7:0] b, input int i,
                                                    input logic q);
    spi_pkg::spi_lanes_t l;
    l = '0;
    if (i < `SPI_BYTE_W) begin
      l.lane0 = b[i];
      if (q) begin
        l.lane1 = b[i+1];
        l.lane2 = b[i+2];
        l.lane3 = b[i+3];
      end
    end
    return l;
  endfunction

  task automatic report_err(input string what, input int got, input int exp);
    test_err = test_err + 1;
    $display("ERR %0t ns: test %0d %s got %0d expected %0d", $time, cur_test, what,
             got, exp);
  endtask

  // --------------------------------------------------
  // Slave model sampling 1 ns after each pclk edge
  // --------------------------------------------------
  initial begin : slave_model
    logic sclk_q;
    logic sel_q;
    logic sel;
    miso    = '0;
    sclk_q  = 1'b0;
    sel_q   = 1'b0;
    slv_cap = '0;
    slv_bit = 0;
    forever begin
      @(posedge pclk);
      #1;
      sel = !cs[exp_slave];
      if (sel && !sel_q) begin
        // First bit goes out as cs falls
        slv_bit = 0;
        slv_cap = '0;
        miso    = lanes_for(exp_reply, 0, exp_quad);
      end else if (sel && sclk && !sclk_q) begin
        // mosi taken on rising sclk
        if (exp_quad) begin
          slv_cap[slv_bit +: 4] = {mosi.lane3, mosi.lane2, mosi.lane1, mosi.lane0};
        end else begin
          slv_cap[slv_bit] = mosi.lane0;
        end
      end else if (sel && !sclk && sclk_q) begin
        // Next bit or nibble after falling sclk
        slv_bit = slv_bit + (exp_quad ? 4 : 1);
        miso    = lanes_for(exp_reply, slv_bit, exp_quad);
      end
      sclk_q = sclk;
      sel_q  = sel;
    end
  end

  // --------------------------------------------------
  // Pin monitor sampling 2 ns after each pclk edge
  // --------------------------------------------------
  initial begin : pin_monitor
    logic sclk_q;
    logic cs_idle_q;
    cyc            = 0;
    accept_cyc     = 0;
    cs_fall_cyc    = 0;
    first_rise_cyc = -1;
    last_fall_cyc  = 0;
    cs_rise_cyc    = 0;
    done_cyc       = 0;
    rise_cnt       = 0;
    done_cnt       = 0;
    sclk_q         = 1'b0;
    cs_idle_q      = 1'b1;
    forever begin
      @(posedge pclk);
      #2;
      cyc = cyc + 1;
      if (!reset) begin
        // Start accepted only while idle
        if (start && !busy) begin
          accept_cyc     = cyc;
          first_rise_cyc = -1;
          rise_cnt       = 0;
        end
        if (cs != '1 && cs_idle_q) begin
          cs_fall_cyc = cyc;
        end
        if (cs == '1 && !cs_idle_q) begin
          cs_rise_cyc = cyc;
        end
        if (sclk && !sclk_q) begin
          rise_cnt = rise_cnt + 1;
          if (first_rise_cyc < 0) begin
            first_rise_cyc = cyc;
          end
        end
        if (!sclk && sclk_q) begin
          last_fall_cyc = cyc;
        end
        if (done) begin
          done_cnt = done_cnt + 1;
          done_cyc = cyc;
        end
        // Only the chosen slave low and lane enables per mode
        if (cs != '1) begin
          if (cs != exp_cs) report_err("cs select", cs, exp_cs);
          if (mosi_oe != exp_oe) report_err("mosi_oe", mosi_oe, exp_oe);
        end
      end
      sclk_q    = sclk;
      cs_idle_q = (cs == '1);
    end
  end

  // --------------------------------------------------
  // One transfer with its checks
  // --------------------------------------------------
  task automatic run_transfer(input int id, input logic quad, input logic stray);
    spi_pkg::spi_cmd_t c;
    spi_pkg::spi_cfg_t f;
    int n;
    int i;
    int done_base;
    int fall_base;
    int exp_rises;
    c.slave    = `SPI_SLV_W'(rand_range(0, `SPI_NUM_SLAVES - 1));
    c.quad     = quad;
    c.tx_byte  = 8'(rand_range(0, 255));
    f.half_div = 8'(rand_range(1, 4));
    f.ct2_dly  = 8'(rand_range(0, 5));
    f.t2c_dly  = 8'(rand_range(0, 5));
    cur_test   = id;
    test_err   = 0;
    // Reference model
    exp_slave  = int'(c.slave);
    exp_quad   = quad;
    exp_reply  = 8'(rand_range(0, 255));
    exp_rises  = `SPI_BYTE_W / (quad ? 4 : 1);
    for (i = 0; i < `SPI_NUM_SLAVES; i++) begin
      exp_cs[i] = (i != exp_slave);
    end
    exp_oe       = '0;
    exp_oe.lane0 = 1'b1;
    exp_oe.lane1 = quad;
    exp_oe.lane2 = quad;
    exp_oe.lane3 = quad;
    done_base    = done_cnt;
    @(posedge pclk);
    #1;
    cmd   = c;
    cfg   = f;
    start = 1'b1;
    @(posedge pclk);
    #1;
    start = 1'b0;
    if (stray) begin
      // Another slave, mode and byte while busy
      @(posedge pclk);
      #1;
      cmd.slave   = c.slave + 1'b1;
      cmd.quad    = !quad;
      cmd.tx_byte = ~c.tx_byte;
      start       = 1'b1;
      @(posedge pclk);
      #1;
      start = 1'b0;
    end
    n = 0;
    while (!done && n < WAIT_MAX) begin
      @(posedge pclk);
      #1;
      n = n + 1;
    end
    if (!done) begin
      timeout_hit = 1'b1;
      $display("Timeout: test %0d saw no done within %0d cycles", id, WAIT_MAX);
      return;
    end
    if (busy) report_err("busy at done", busy, 0);
    if (rx_data != exp_reply) report_err("rx_data", rx_data, exp_reply);
    fall_base = cs_fall_cyc;
    // Gap covers a whole second transfer after a stray start
    repeat (stray ? 120 : 3) @(posedge pclk);
    #1;
    if (slv_cap != c.tx_byte) report_err("slave capture", slv_cap, c.tx_byte);
    if (rise_cnt != exp_rises) report_err("sclk rises", rise_cnt, exp_rises);
    if (cs_fall_cyc != accept_cyc + 1) begin
      report_err("start to cs fall", cs_fall_cyc - accept_cyc, 1);
    end
    if (first_rise_cyc - cs_fall_cyc != int'(f.ct2_dly) + int'(f.half_div)) begin
      report_err("cs fall to first rise", first_rise_cyc - cs_fall_cyc,
                 int'(f.ct2_dly) + int'(f.half_div));
    end
    if (cs_rise_cyc - last_fall_cyc != int'(f.t2c_dly) + 1) begin
      report_err("last fall to cs rise", cs_rise_cyc - last_fall_cyc, int'(f.t2c_dly) + 1);
    end
    if (done_cyc != cs_rise_cyc + 1) report_err("cs rise to done", done_cyc - cs_rise_cyc, 1);
    if (done_cnt != done_base + 1) report_err("done pulses", done_cnt - done_base, 1);
    if (cs_fall_cyc != fall_base) report_err("extra cs fall", cs_fall_cyc - fall_base, 0);
    if (test_err == 0) begin
      n_pass = n_pass + 1;
      $display("test %0d %s slave %0d: ok", id, quad ? "quad" : "single", exp_slave);
    end else begin
      n_fail = n_fail + 1;
      $display("test %0d %s slave %0d: %0d errors", id, quad ? "quad" : "single", exp_slave,
               test_err);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main_seq
    int n;
    int id;
    int q;
    int k;
    seed        = 32'h5dc0dd05;
    start       = 1'b0;
    cmd         = '0;
    cfg         = '0;
    n_pass      = 0;
    n_fail      = 0;
    test_err    = 0;
    cur_test    = 0;
    timeout_hit = 1'b0;
    exp_slave   = 0;
    exp_quad    = 1'b0;
    exp_reply   = '0;
    exp_cs      = '1;
    exp_oe      = '0;
    n = 0;
    @(posedge pclk);
    while (reset && n < WAIT_MAX) begin
      @(posedge pclk);
      n = n + 1;
    end
    if (reset) begin
      timeout_hit = 1'b1;
      $display("Timeout: reset was never released");
    end else begin
      // First cycle with reset low
      #1;
      if (cs != '1) report_err("cs after reset", cs, (1 << `SPI_NUM_SLAVES) - 1);
      if (sclk) report_err("sclk after reset", sclk, 0);
      if (busy) report_err("busy after reset", busy, 0);
      if (done) report_err("done after reset", done, 0);
      if (mosi_oe != '0) report_err("mosi_oe after reset", mosi_oe, 0);
      if (test_err == 0) begin
        n_pass = n_pass + 1;
        $display("test 0 reset: ok");
      end else begin
        n_fail = n_fail + 1;
        $display("test 0 reset: %0d errors", test_err);
      end
    end
    id = 1;
    for (q = 0; q < 2; q++) begin
      for (k = 0; k < N_EACH; k++) begin
        if (!timeout_hit) begin
          run_transfer(id, q[0], (k % 5) == 4);
        end
        id = id + 1;
      end
    end
    $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && !timeout_hit) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+.
spi_pkg.sv
spi_sclk_gen.sv
spi_shift_engine.sv
spi_master_ctrl.sv
spi_master_top.sv
tb_spi_clk.sv
tb_spi_master.sv

// File: Makefile
# Verilator build and run of the SPI master testbench
# Any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation result found in $(LOG)"; \
	else \
	  echo "No pass line in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
